//--- rtl/kbd_pkg.sv
/*
 * Shared types, constants and state encodings for the keyboard matrix logic.
 * Imported by every module of the keyboard block and by its testbench.
 */
package kbd_pkg;

   typedef logic [3:0] row_t;       // matrix row number
   typedef logic [7:0] column_t;    // one-hot key bits of a row
   typedef logic [7:0] scan_code_t;

   localparam row_t ROW_NONE     = 4'd15;  // no key held
   localparam row_t ROW_MODIFIER = 4'd8;

   localparam column_t MOD_SHIFT_BIT = 8'h40;
   localparam column_t MOD_KANA_BIT  = 8'h20;
   localparam column_t MOD_CTRL_BIT  = 8'h80;

   localparam logic [3:0] SCAN_RELEASE_COUNT = 4'd13; // 14th scan releases

   localparam scan_code_t CODE_BREAK = 8'hF0;
   localparam scan_code_t CODE_SHIFT = 8'h12;
   localparam scan_code_t CODE_KANA  = 8'h13;
   localparam scan_code_t CODE_CTRL  = 8'h14;

   // ****************************************
   // scan codes per matrix row
   // ****************************************
   localparam scan_code_t KEY_ENTER     = 8'h5A; // row 1
   localparam scan_code_t KEY_AT        = 8'h54; // row 2
   localparam scan_code_t KEY_A         = 8'h1C;
   localparam scan_code_t KEY_B         = 8'h32;
   localparam scan_code_t KEY_C         = 8'h21;
   localparam scan_code_t KEY_D         = 8'h23;
   localparam scan_code_t KEY_E         = 8'h24;
   localparam scan_code_t KEY_F         = 8'h2B;
   localparam scan_code_t KEY_G         = 8'h34;
   localparam scan_code_t KEY_H         = 8'h33; // row 3
   localparam scan_code_t KEY_I         = 8'h43;
   localparam scan_code_t KEY_J         = 8'h3B;
   localparam scan_code_t KEY_K         = 8'h42;
   localparam scan_code_t KEY_L         = 8'h4B;
   localparam scan_code_t KEY_M         = 8'h3A;
   localparam scan_code_t KEY_N         = 8'h31;
   localparam scan_code_t KEY_O         = 8'h44;
   localparam scan_code_t KEY_P         = 8'h4D; // row 4
   localparam scan_code_t KEY_Q         = 8'h15;
   localparam scan_code_t KEY_R         = 8'h2D;
   localparam scan_code_t KEY_S         = 8'h1B;
   localparam scan_code_t KEY_T         = 8'h2C;
   localparam scan_code_t KEY_U         = 8'h3C;
   localparam scan_code_t KEY_V         = 8'h2A;
   localparam scan_code_t KEY_W         = 8'h1D;
   localparam scan_code_t KEY_X         = 8'h22; // row 5
   localparam scan_code_t KEY_Y         = 8'h35;
   localparam scan_code_t KEY_Z         = 8'h1A;
   localparam scan_code_t KEY_LBRACKET  = 8'h5B;
   localparam scan_code_t KEY_YEN       = 8'h6A;
   localparam scan_code_t KEY_RBRACKET  = 8'h5D;
   localparam scan_code_t KEY_CARET     = 8'h55;
   localparam scan_code_t KEY_MINUS     = 8'h4E;
   localparam scan_code_t KEY_0         = 8'h45; // row 6
   localparam scan_code_t KEY_1         = 8'h16;
   localparam scan_code_t KEY_2         = 8'h1E;
   localparam scan_code_t KEY_3         = 8'h26;
   localparam scan_code_t KEY_4         = 8'h25;
   localparam scan_code_t KEY_5         = 8'h2E;
   localparam scan_code_t KEY_6         = 8'h36;
   localparam scan_code_t KEY_7         = 8'h3D;
   localparam scan_code_t KEY_8         = 8'h3E; // row 7
   localparam scan_code_t KEY_9         = 8'h46;
   localparam scan_code_t KEY_COLON     = 8'h52;
   localparam scan_code_t KEY_SEMICOLON = 8'h4C;
   localparam scan_code_t KEY_COMMA     = 8'h41;
   localparam scan_code_t KEY_DOT       = 8'h49;
   localparam scan_code_t KEY_SLASH     = 8'h4A;
   localparam scan_code_t KEY_HOME      = 8'h6C; // row 8, also clr
   localparam scan_code_t KEY_DOWN      = 8'h72;
   localparam scan_code_t KEY_RIGHT     = 8'h6B;
   localparam scan_code_t KEY_DEL       = 8'h71;
   localparam scan_code_t KEY_STOP      = 8'h77; // row 9, pause key
   localparam scan_code_t KEY_F1        = 8'h05;
   localparam scan_code_t KEY_F2        = 8'h06;
   localparam scan_code_t KEY_F3        = 8'h04;
   localparam scan_code_t KEY_F4        = 8'h0C;
   localparam scan_code_t KEY_F5        = 8'h03;
   localparam scan_code_t KEY_SPACE     = 8'h29;
   localparam scan_code_t KEY_ESC       = 8'h76;

   typedef enum logic [2:0] {
      KIND_MATRIX,
      KIND_BREAK,
      KIND_SHIFT,
      KIND_KANA,
      KIND_CTRL
   } key_kind_e;

   typedef enum logic {
      LATCH_EMPTY,
      LATCH_HELD
   } latch_state_e;

endpackage

//--- rtl/scancode_decoder.sv
/*
 * Combinational scan code decoder. Gives the key kind, and for matrix keys
 * the row and one-hot column byte. Unknown codes map to an empty key.
 */
module scancode_decoder
   import kbd_pkg::*;
(
   input  scan_code_t code,
   output key_kind_e  key_kind,
   output row_t       key_row,
   output column_t    key_column
);

   logic [11:0] key_pos; // {row, column}

   assign key_row    = key_pos[11:8];
   assign key_column = key_pos[7:0];

   always_comb begin
      key_kind = KIND_MATRIX;
      key_pos  = {ROW_NONE, 8'h00}; // unmapped code, empty key
      case (code)
         // ****************************************
         // control codes
         // ****************************************
         CODE_BREAK    : key_kind = KIND_BREAK;
         CODE_SHIFT    : key_kind = KIND_SHIFT;
         CODE_KANA     : key_kind = KIND_KANA;
         CODE_CTRL     : key_kind = KIND_CTRL;
         // ****************************************
         // matrix keys
         // ****************************************
         KEY_ENTER     : key_pos = {4'd1, 8'h80};
         KEY_AT        : key_pos = {4'd2, 8'h01};
         KEY_A         : key_pos = {4'd2, 8'h02};
         KEY_B         : key_pos = {4'd2, 8'h04};
         KEY_C         : key_pos = {4'd2, 8'h08};
         KEY_D         : key_pos = {4'd2, 8'h10};
         KEY_E         : key_pos = {4'd2, 8'h20};
         KEY_F         : key_pos = {4'd2, 8'h40};
         KEY_G         : key_pos = {4'd2, 8'h80};
         KEY_H         : key_pos = {4'd3, 8'h01};
         KEY_I         : key_pos = {4'd3, 8'h02};
         KEY_J         : key_pos = {4'd3, 8'h04};
         KEY_K         : key_pos = {4'd3, 8'h08};
         KEY_L         : key_pos = {4'd3, 8'h10};
         KEY_M         : key_pos = {4'd3, 8'h20};
         KEY_N         : key_pos = {4'd3, 8'h40};
         KEY_O         : key_pos = {4'd3, 8'h80};
         KEY_P         : key_pos = {4'd4, 8'h01};
         KEY_Q         : key_pos = {4'd4, 8'h02};
         KEY_R         : key_pos = {4'd4, 8'h04};
         KEY_S         : key_pos = {4'd4, 8'h08};
         KEY_T         : key_pos = {4'd4, 8'h10};
         KEY_U         : key_pos = {4'd4, 8'h20};
         KEY_V         : key_pos = {4'd4, 8'h40};
         KEY_W         : key_pos = {4'd4, 8'h80};
         KEY_X         : key_pos = {4'd5, 8'h01};
         KEY_Y         : key_pos = {4'd5, 8'h02};
         KEY_Z         : key_pos = {4'd5, 8'h04};
         KEY_LBRACKET  : key_pos = {4'd5, 8'h08};
         KEY_YEN       : key_pos = {4'd5, 8'h10};
         KEY_RBRACKET  : key_pos = {4'd5, 8'h20};
         KEY_CARET     : key_pos = {4'd5, 8'h40};
         KEY_MINUS     : key_pos = {4'd5, 8'h80};
         KEY_0         : key_pos = {4'd6, 8'h01};
         KEY_1         : key_pos = {4'd6, 8'h02};
         KEY_2         : key_pos = {4'd6, 8'h04};
         KEY_3         : key_pos = {4'd6, 8'h08};
         KEY_4         : key_pos = {4'd6, 8'h10};
         KEY_5         : key_pos = {4'd6, 8'h20};
         KEY_6         : key_pos = {4'd6, 8'h40};
         KEY_7         : key_pos = {4'd6, 8'h80};
         KEY_8         : key_pos = {4'd7, 8'h01};
         KEY_9         : key_pos = {4'd7, 8'h02};
         KEY_COLON     : key_pos = {4'd7, 8'h04};
         KEY_SEMICOLON : key_pos = {4'd7, 8'h08};
         KEY_COMMA     : key_pos = {4'd7, 8'h10};
         KEY_DOT       : key_pos = {4'd7, 8'h20};
         KEY_SLASH     : key_pos = {4'd7, 8'h40};
         // row 8 shares its upper bits with the modifier byte
         KEY_HOME      : key_pos = {4'd8, 8'h01};
         KEY_DOWN      : key_pos = {4'd8, 8'h02};
         KEY_RIGHT     : key_pos = {4'd8, 8'h04};
         KEY_DEL       : key_pos = {4'd8, 8'h08};
         KEY_STOP      : key_pos = {4'd9, 8'h01};
         KEY_F1        : key_pos = {4'd9, 8'h02};
         KEY_F2        : key_pos = {4'd9, 8'h04};
         KEY_F3        : key_pos = {4'd9, 8'h08};
         KEY_F4        : key_pos = {4'd9, 8'h10};
         KEY_F5        : key_pos = {4'd9, 8'h20};
         KEY_SPACE     : key_pos = {4'd9, 8'h40};
         KEY_ESC       : key_pos = {4'd9, 8'h80};
         default       : key_pos = {ROW_NONE, 8'h00};
      endcase
   end

endmodule

//--- rtl/key_latch.sv
/*
 * Holds the last pressed matrix key and the modifier flags. The key and
 * modifiers are released once the CPU has scanned port 00h enough times.
 */
module key_latch
   import kbd_pkg::*;
(
   input  logic      I_CLK,
   input  logic      I_RST,
   input  key_kind_e key_kind,
   input  row_t      key_row,
   input  column_t   key_column,
   input  logic      code_valid,
   input  logic      scan_strobe,
   output row_t      held_row,
   output column_t   held_column,
   output logic      shift_on,
   output logic      kana_on,
   output logic      ctrl_on
);

   latch_state_e state;
   logic         break_armed;   // F0h seen, next code is a release
   logic [3:0]   scan_cnt;

   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         state       <= LATCH_EMPTY;
         break_armed <= 1'b0;
         scan_cnt    <= 4'd0;
         held_row    <= ROW_NONE;
         held_column <= 8'h00;
         shift_on    <= 1'b0;
         kana_on     <= 1'b0;
         ctrl_on     <= 1'b0;
      end
      else if (code_valid) begin
         // new codes win over a scan in the same cycle
         if (key_kind == KIND_BREAK) begin
            break_armed <= 1'b1;
         end
         else if (break_armed) begin
            break_armed <= 1'b0; // key release, nothing else to do
         end
         else begin
            case (key_kind)
               KIND_SHIFT : shift_on <= 1'b1;
               KIND_KANA  : kana_on  <= 1'b1;
               KIND_CTRL  : ctrl_on  <= 1'b1;
               default : begin
                  held_row    <= key_row;
                  held_column <= key_column;
                  state       <= LATCH_HELD;
               end
            endcase
         end
      end
      // ****************************************
      // release after enough CPU scans
      // ****************************************
      else if ((state == LATCH_HELD) && scan_strobe) begin
         if (scan_cnt == SCAN_RELEASE_COUNT) begin
            state       <= LATCH_EMPTY;
            scan_cnt    <= 4'd0;
            held_row    <= ROW_NONE;
            held_column <= 8'h00;
            shift_on    <= 1'b0; // modifiers go with the key
            kana_on     <= 1'b0;
            ctrl_on     <= 1'b0;
         end
         else begin
            scan_cnt <= scan_cnt + 4'd1;
         end
      end
   end

endmodule

//--- rtl/cpu_port_reader.sv
/*
 * CPU side of the keyboard. Turns the end of a port 00h access into a scan
 * strobe and registers the matrix byte for the row the CPU addresses.
 */
module cpu_port_reader
   import kbd_pkg::*;
(
   input  logic    I_CLK,
   input  logic    I_RST,
   input  logic    cpu_iorq,
   input  logic    cpu_port00h,
   input  row_t    cpu_addr,
   input  row_t    held_row,
   input  column_t held_column,
   input  logic    shift_on,
   input  logic    kana_on,
   input  logic    ctrl_on,
   output logic    scan_strobe,
   output column_t kb_data
);

   logic [1:0] iorq_sreg; // [0] newest sample
   column_t    read_byte;

   // iorq idles high, so start the sampler there
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         iorq_sreg <= 2'b11;
      end
      else begin
         iorq_sreg <= {iorq_sreg[0], cpu_iorq};
      end
   end

   // rise of iorq marks the end of the access
   assign scan_strobe = ~iorq_sreg[1] & iorq_sreg[0] & cpu_port00h;

   // ****************************************
   // read byte select
   // ****************************************
   always_comb begin
      if ((cpu_addr == ROW_MODIFIER) && shift_on)
         read_byte = MOD_SHIFT_BIT;
      else if ((cpu_addr == ROW_MODIFIER) && kana_on)
         read_byte = MOD_KANA_BIT;
      else if ((cpu_addr == ROW_MODIFIER) && ctrl_on)
         read_byte = MOD_CTRL_BIT;
      else if (cpu_addr == held_row)
         read_byte = held_column;
      else
         read_byte = 8'h00;
   end

   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         kb_data <= 8'h00;
      end
      else begin
         kb_data <= read_byte;
      end
   end

endmodule

//--- rtl/pc8001_keyboard.sv
/*
 * Keyboard block top level. Scan codes go through the decoder into the key
 * latch, and the CPU reads matrix rows through the port reader.
 */
module pc8001_keyboard
   import kbd_pkg::*;
(
   input  logic       I_CLK,
   input  logic       I_RST,
   input  scan_code_t ps2_code,
   input  logic       ps2_code_valid,
   input  row_t       cpu_addr,
   input  logic       cpu_iorq,      // active low
   input  logic       cpu_port00h,
   output column_t    kb_data
);

   key_kind_e key_kind;
   row_t      key_row;
   column_t   key_column;
   row_t      held_row;
   column_t   held_column;
   logic      shift_on;
   logic      kana_on;
   logic      ctrl_on;
   logic      scan_strobe;   // end of a port 00h access

   scancode_decoder i_scancode_decoder (
      .code       (ps2_code),
      .key_kind   (key_kind),
      .key_row    (key_row),
      .key_column (key_column)
   );

   key_latch i_key_latch (
      .I_CLK       (I_CLK),
      .I_RST       (I_RST),
      .key_kind    (key_kind),
      .key_row     (key_row),
      .key_column  (key_column),
      .code_valid  (ps2_code_valid),
      .scan_strobe (scan_strobe),
      .held_row    (held_row),
      .held_column (held_column),
      .shift_on    (shift_on),
      .kana_on     (kana_on),
      .ctrl_on     (ctrl_on)
   );

   cpu_port_reader i_cpu_port_reader (
      .I_CLK       (I_CLK),
      .I_RST       (I_RST),
      .cpu_iorq    (cpu_iorq),
      .cpu_port00h (cpu_port00h),
      .cpu_addr    (cpu_addr),
      .held_row    (held_row),
      .held_column (held_column),
      .shift_on    (shift_on),
      .kana_on     (kana_on),
      .ctrl_on     (ctrl_on),
      .scan_strobe (scan_strobe),
      .kb_data     (kb_data)
   );

endmodule

//--- sim/tb_pc8001_keyboard.sv
/*
 * Testbench for the keyboard block. Commands come from the data file as
 * scan codes, port 00h scans and row reads checked against expected bytes.
 */
module tb_pc8001_keyboard
   import kbd_pkg::*;
();

   logic       I_CLK = 1'b0;
   logic       I_RST;
   scan_code_t ps2_code;
   logic       ps2_code_valid;
   row_t       cpu_addr;
   logic       cpu_iorq;      // active low
   logic       cpu_port00h;
   column_t    kb_data;

   // command list from the data file
   logic [7:0]   cmd_q[$];
   logic [191:0] name_q[$];
   logic [7:0]   arg_a_q[$];
   logic [7:0]   arg_b_q[$];

   logic [7:0]   cur_arg_a;
   int unsigned  scan_total  = 0;
   int unsigned  cycle_limit = 32'hFFFF_FFFF; // set once the file is loaded
   int unsigned  cycle_cnt   = 0;

   pc8001_keyboard i_pc8001_keyboard (
      .I_CLK          (I_CLK),
      .I_RST          (I_RST),
      .ps2_code       (ps2_code),
      .ps2_code_valid (ps2_code_valid),
      .cpu_addr       (cpu_addr),
      .cpu_iorq       (cpu_iorq),
      .cpu_port00h    (cpu_port00h),
      .kb_data        (kb_data)
   );

   always #50 I_CLK = ~I_CLK; // 100 unit period

   // ****************************************
   // run limit
   // ****************************************
   always @(posedge I_CLK) begin
      cycle_cnt <= cycle_cnt + 1;
      assert (cycle_cnt < cycle_limit) else begin
         $display("Run stopped, cycle limit of %0d reached before the last command",
                  cycle_limit);
         stop_on_failure();
      end
   end

   task automatic stop_on_failure();
      $display("Test failed");
      $fatal(1, "stopping at the first error");
   endtask

   // one clock, then the drive point just after the edge
   task automatic step();
      @(posedge I_CLK);
      #10;
   endtask

   task automatic send_code(input scan_code_t code);
      ps2_code       = code;
      ps2_code_valid = 1'b1;
      step();
      ps2_code_valid = 1'b0;
      repeat (2) step();
   endtask

   // each scan is one full port 00h access by the CPU
   task automatic run_scans(input logic [7:0] count);
      repeat (count) begin
         cpu_port00h = 1'b1;
         cpu_iorq = 1'b0;
         repeat (3) step();
         cpu_iorq = 1'b1;          // rise ends the access
         repeat (3) step();
         cpu_port00h = 1'b0;
      end
   endtask

   task automatic check_row(input logic [191:0] name, input row_t row,
                            input column_t expected);
      cpu_addr = row;
      repeat (2) step();        // address in, then registered byte out
      assert (kb_data == expected) else begin
         $display("** Error %0s: row %0d expected %02h, actual %02h",
                  name, row, expected, kb_data);
         stop_on_failure();
      end
   endtask

   // ****************************************
   // data file reader
   // ****************************************
   task automatic load_commands();
      int           fd;
      int           items;
      int           ch;
      logic [7:0]   cmd;
      logic [191:0] name;
      logic [7:0]   arg_a;
      logic [7:0]   arg_b;
      fd = $fopen("sim/keyboard_testdata.txt", "r");
      assert (fd != 0) else begin
         $display("Cannot open the data file sim/keyboard_testdata.txt");
         stop_on_failure();
      end
      items = $fscanf(fd, "%s", cmd);
      while (items == 1) begin
         if (cmd == "#") begin
            ch = $fgetc(fd);    // skip the rest of a comment line
            while ((ch != 10) && (ch != -1))
               ch = $fgetc(fd);
         end
         else begin
            assert ((cmd == "K") || (cmd == "S") || (cmd == "R")) else begin
               $display("Unknown command %c in the data file", cmd);
               stop_on_failure();
            end
            arg_b = 8'h00;
            items = $fscanf(fd, "%s %h", name, arg_a);
            if (cmd == "R")
               items = items + $fscanf(fd, "%h", arg_b);
            assert (items == ((cmd == "R") ? 3 : 2)) else begin
               $display("Data file line for %0s has missing fields", name);
               stop_on_failure();
            end
            if (cmd == "S")
               scan_total = scan_total + {24'd0, arg_a};
            cmd_q.push_back(cmd);
            name_q.push_back(name);
            arg_a_q.push_back(arg_a);
            arg_b_q.push_back(arg_b);
         end
         items = $fscanf(fd, "%s", cmd);
      end
      $fclose(fd);
   endtask

   // ****************************************
   // main sequence
   // ****************************************
   initial begin
      I_RST          = 1'b1;
      ps2_code       = 8'h00;
      ps2_code_valid = 1'b0;
      cpu_addr       = 4'd0;
      cpu_iorq       = 1'b1;   // bus idle
      cpu_port00h    = 1'b0;
      cur_arg_a      = 8'h00;

      load_commands();
      cycle_limit = 16 + 20 * cmd_q.size() + 6 * scan_total;

      repeat (16) @(posedge I_CLK);
      #10;
      I_RST = 1'b0;
      step();

      for (int i = 0; i < cmd_q.size(); i++) begin
         cur_arg_a = arg_a_q[i];
         case (cmd_q[i])
            "K"     : send_code(cur_arg_a);
            "S"     : run_scans(cur_arg_a);
            default : check_row(name_q[i], cur_arg_a[3:0], arg_b_q[i]);
         endcase
      end

      $display("Test completed successfully");
      $finish;
   end

endmodule

//--- sim/keyboard_testdata.txt
# columns: command, test name, hex fields
# K name code | S name scan count | R name row expected byte
# key A, then enter overwrites it
K press_a          1C
R a_on_row2        02 02
R a_row3_empty     03 00
K press_enter      5A
R enter_on_row1    01 80
R enter_row2_empty 02 00
# release on the 14th port 00h scan
S scans_13         0D
R held_after_13    01 80
S scan_14          01
R released_row1    01 00
# shift with a key, cleared by the release
K press_shift      12
K press_d          23
R shift_on_row8    08 40
R d_on_row2        02 10
S release_d        0E
R shift_cleared    08 00
R d_cleared        02 00
# kana and ctrl alone, shift priority
K press_kana       13
R kana_on_row8     08 20
S idle_scans       03
R kana_kept        08 20
K press_q          15
R kana_with_q      08 20
R q_on_row4        04 02
S release_q        0E
R kana_cleared     08 00
K press_ctrl       14
R ctrl_on_row8     08 80
S idle_scans_2     02
R ctrl_kept        08 80
K press_shift_2    12
R shift_over_ctrl  08 40
K press_home       6C
R shift_over_home  08 40
S release_home     0E
R mods_cleared     08 00
# break codes and an unmapped code
K press_s          1B
R s_on_row4        04 08
K break_prefix     F0
K release_s        1B
R s_after_release  04 08
K break_prefix_2   F0
K release_w        1D
R s_kept           04 08
K press_unmapped   07
R unmapped_row4    04 00
R unmapped_row8    08 00
K shift_unmapped   12
S scans_13_empty   0D
R shift_kept       08 40
S scan_14_empty    01
R shift_released   08 00

//--- sources.f
rtl/kbd_pkg.sv
rtl/scancode_decoder.sv
rtl/key_latch.sv
rtl/cpu_port_reader.sv
rtl/pc8001_keyboard.sv
sim/tb_pc8001_keyboard.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the keyboard testbench

TOP=tb_pc8001_keyboard
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module "$TOP" -o "V$TOP"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi
